/* adc_pkg.sv */
//----------------------------------------
// adc capture shared definitions
//----------------------------------------

package adc_pkg;

  // sample and register widths
  localparam int sample_w = 16;
  localparam int reg_w    = 16;
  // averaging depth field, k = 0..7
  localparam int avg_w    = 3;
  // room for 2^7 full-scale samples
  localparam int acc_w    = sample_w + 7;
  localparam int cnt_w    = 16;

  //----------------------------------------
  // register map
  //----------------------------------------
  localparam logic [1:0] addr_ctrl   = 2'd0;
  localparam logic [1:0] addr_period = 2'd1;
  localparam logic [1:0] addr_result = 2'd2;
  localparam logic [1:0] addr_count  = 2'd3;

  // one conversion is 34 cycles plus sync delay, keep margin
  localparam logic [reg_w-1:0] period_min = 16'd48;
  localparam logic [reg_w-1:0] period_rst = 16'd64;

  // control register layout, enable in bit 0
  typedef struct packed {
    logic [11:0]      reserved;
    logic [avg_w-1:0] avg_log2;
    logic             enable;
  } ctrl_t;

  // same word seen as fields or as raw data
  typedef union packed {
    ctrl_t            ctrl;
    logic [reg_w-1:0] raw;
  } reg_word_t;

endpackage

/* adc_regs.sv */
//----------------------------------------
// adc capture register block
//----------------------------------------

`timescale 1ns/1ps

module adc_regs (
  input  logic                         clk33,
  input  logic                         rst,
  // write side
  input  logic                         wr_en,
  input  logic [1:0]                   wr_addr,
  input  logic [adc_pkg::reg_w-1:0]    wr_data,
  // combinational read side
  input  logic [1:0]                   rd_addr,
  output logic [adc_pkg::reg_w-1:0]    rd_data,
  // results from the averager
  input  logic                         avg_valid,
  input  logic [adc_pkg::sample_w-1:0] avg_data,
  // configuration out
  output logic                         enable,
  output logic [adc_pkg::avg_w-1:0]    avg_log2,
  output logic [adc_pkg::reg_w-1:0]    period,
  output logic                         avg_clear
);

  adc_pkg::reg_word_t wr_word;
  adc_pkg::reg_word_t rd_word;

  // last mean and number of means seen
  logic [adc_pkg::sample_w-1:0] result;
  logic [adc_pkg::cnt_w-1:0]    count;

  // incoming write decoded as control fields
  assign wr_word.raw = wr_data;

  //----------------------------------------
  // write path
  //----------------------------------------
  always_ff @(posedge clk33) begin
    if (rst) begin
      enable    <= 1'b0;
      avg_log2  <= '0;
      period    <= adc_pkg::period_rst;
      avg_clear <= 1'b0;
      result    <= '0;
      count     <= '0;
    end else begin
      avg_clear <= 1'b0;
      if (wr_en) begin
        case (wr_addr)
          adc_pkg::addr_ctrl: begin
            enable    <= wr_word.ctrl.enable;
            avg_log2  <= wr_word.ctrl.avg_log2;
            // new depth, drop the partial group
            avg_clear <= 1'b1;
          end
          adc_pkg::addr_period: begin
            // clamp so a conversion always fits in one period
            if (wr_word.raw < adc_pkg::period_min) begin
              period <= adc_pkg::period_min;
            end else begin
              period <= wr_word.raw;
            end
          end
          // result and count are read only
          default: ;
        endcase
      end
      if (avg_valid) begin
        result <= avg_data;
        // free running, wraps at 2^cnt_w
        count  <= count + 1'b1;
      end
    end
  end

  //----------------------------------------
  // readback
  //----------------------------------------
  always_comb begin
    rd_word               = '0;
    rd_word.ctrl.avg_log2 = avg_log2;
    rd_word.ctrl.enable   = enable;
    case (rd_addr)
      adc_pkg::addr_ctrl:   rd_data = rd_word.raw;
      adc_pkg::addr_period: rd_data = period;
      adc_pkg::addr_result: rd_data = result;
      default:              rd_data = count;
    endcase
  end

  // timer relies on the clamp for its reload values
  period_floor_a : assert property (
    @(posedge clk33) disable iff (rst) period >= adc_pkg::period_min
  );

endmodule

/* adc_conv_timer.sv */
//----------------------------------------
// conversion start timer
//----------------------------------------

`timescale 1ns/1ps

module adc_conv_timer (
  input  logic                      clk33,
  input  logic                      rst,
  input  logic                      enable,
  input  logic [adc_pkg::reg_w-1:0] period,
  // receiver still collecting a frame
  input  logic                      rx_busy,
  // active low start, one cycle wide
  output logic                      n_conv
);

  logic                      enable_q;
  logic [adc_pkg::reg_w-1:0] cnt;
  // period ran out while the receiver was busy
  logic                      pending;

  always_ff @(posedge clk33) begin
    if (rst) begin
      enable_q <= 1'b0;
      cnt      <= '0;
      pending  <= 1'b0;
      n_conv   <= 1'b1;
    end else begin
      enable_q <= enable;
      // default idle, low only for one cycle
      n_conv   <= 1'b1;
      if (!enable) begin
        pending <= 1'b0;
      end else if (!enable_q) begin
        // first pulse lands period cycles after enable rises
        cnt <= period - 16'd2;
      end else if (pending || cnt == '0) begin
        if (rx_busy) begin
          // hold the start until the frame is in
          pending <= 1'b1;
        end else begin
          n_conv  <= 1'b0;
          pending <= 1'b0;
          // next start one full period later
          cnt     <= period - 16'd1;
        end
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // the adc must see a single low sample per conversion
  single_start_a : assert property (
    @(posedge clk33) disable iff (rst) !n_conv |=> n_conv
  );

endmodule

/* adc_serial_rx.sv */
//----------------------------------------
// serial adc frame receiver
//----------------------------------------

`timescale 1ns/1ps

module adc_serial_rx (
  input  logic                         clk33,
  input  logic                         rst,
  // adc pins, treated as asynchronous
  input  logic                         busy,
  input  logic                         sclk,
  input  logic                         sdout,
  output logic                         rx_busy,
  output logic                         sample_valid,
  output logic [adc_pkg::sample_w-1:0] sample
);

  //----------------------------------------
  // two flop synchronizers
  //----------------------------------------
  logic busy_m, busy_s, busy_q;
  logic sclk_m, sclk_s, sclk_q;
  logic sdout_m, sdout_s;

  always_ff @(posedge clk33) begin
    if (rst) begin
      busy_m <= 1'b0;
      busy_s <= 1'b0;
      busy_q <= 1'b0;
      sclk_m <= 1'b0;
      sclk_s <= 1'b0;
      sclk_q <= 1'b0;
    end else begin
      busy_m <= busy;
      busy_s <= busy_m;
      busy_q <= busy_s;
      sclk_m <= sclk;
      sclk_s <= sclk_m;
      sclk_q <= sclk_s;
    end
  end

  // data path, same depth as sclk so bits stay aligned
  always_ff @(posedge clk33) begin
    sdout_m <= sdout;
    sdout_s <= sdout_m;
  end

  //----------------------------------------
  // shifter and bit counter
  //----------------------------------------
  logic       sclk_rise;
  logic       busy_fall;
  logic [4:0] bit_cnt;

  assign sclk_rise = sclk_s & ~sclk_q;
  assign busy_fall = busy_q & ~busy_s;

  always_ff @(posedge clk33) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (!busy_s) begin
      // idle, ready for the next frame
      bit_cnt <= '0;
    end else if (sclk_rise) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // msb first, bit valid while sclk is high
  always_ff @(posedge clk33) begin
    if (busy_s && sclk_rise) begin
      sample <= {sample[adc_pkg::sample_w-2:0], sdout_s};
    end
  end

  assign rx_busy = busy_s;
  // full frames only, short frames vanish
  assign sample_valid = busy_fall && (bit_cnt == 5'd16);

  // device must not clock more than one sample per busy window
  frame_len_a : assert property (
    @(posedge clk33) disable iff (rst) bit_cnt <= 5'd16
  );

endmodule

/* adc_avg.sv */
//----------------------------------------
// power of two sample averager
//----------------------------------------

`timescale 1ns/1ps

module adc_avg (
  input  logic                         clk33,
  input  logic                         rst,
  input  logic [adc_pkg::avg_w-1:0]    avg_log2,
  // restart the group, depth just changed
  input  logic                         avg_clear,
  input  logic                         sample_valid,
  input  logic [adc_pkg::sample_w-1:0] sample,
  output logic                         avg_valid,
  output logic [adc_pkg::sample_w-1:0] avg_data
);

  // samples taken so far in the group, 0..127
  logic [adc_pkg::acc_w-adc_pkg::sample_w-1:0] n;
  logic [adc_pkg::acc_w-adc_pkg::sample_w-1:0] n_base;
  logic [adc_pkg::acc_w-adc_pkg::sample_w-1:0] grp_mask;
  logic [adc_pkg::acc_w-1:0]                   acc;
  logic [adc_pkg::acc_w-1:0]                   acc_base;
  logic [adc_pkg::acc_w-1:0]                   sum;
  logic [adc_pkg::acc_w-1:0]                   mean;
  logic                                        last;

  // low k bits set, last sample when n reaches 2^k - 1
  assign grp_mask = ~({(adc_pkg::acc_w-adc_pkg::sample_w){1'b1}} << avg_log2);

  // a sample arriving with the clear opens the new group
  assign acc_base = avg_clear ? '0 : acc;
  assign n_base   = avg_clear ? '0 : n;

  assign sum  = acc_base + {{(adc_pkg::acc_w-adc_pkg::sample_w){1'b0}}, sample};
  assign last = (n_base == grp_mask);
  // floor of sum / 2^k
  assign mean = sum >> avg_log2;

  //----------------------------------------
  // accumulate and emit
  //----------------------------------------
  always_ff @(posedge clk33) begin
    if (rst) begin
      acc       <= '0;
      n         <= '0;
      avg_valid <= 1'b0;
    end else begin
      avg_valid <= 1'b0;
      if (sample_valid) begin
        if (last) begin
          avg_valid <= 1'b1;
          acc       <= '0;
          n         <= '0;
        end else begin
          acc <= sum;
          n   <= n_base + 1'b1;
        end
      end else if (avg_clear) begin
        acc <= '0;
        n   <= '0;
      end
    end
  end

  // mean always fits a sample width
  always_ff @(posedge clk33) begin
    if (sample_valid && last) begin
      avg_data <= mean[adc_pkg::sample_w-1:0];
    end
  end

endmodule

/* adc_capture_top.sv */
//----------------------------------------
// adc capture path top level
//----------------------------------------

`timescale 1ns/1ps

module adc_capture_top (
  input  logic                         clk33,
  input  logic                         rst,
  // register access
  input  logic                         wr_en,
  input  logic [1:0]                   wr_addr,
  input  logic [adc_pkg::reg_w-1:0]    wr_data,
  input  logic [1:0]                   rd_addr,
  output logic [adc_pkg::reg_w-1:0]    rd_data,
  // adc pins
  output logic                         n_conv,
  input  logic                         busy,
  input  logic                         sclk,
  input  logic                         sdout,
  // averaged result
  output logic                         avg_valid,
  output logic [adc_pkg::sample_w-1:0] avg_data
);

  logic                         enable;
  logic [adc_pkg::avg_w-1:0]    avg_log2;
  logic [adc_pkg::reg_w-1:0]    period;
  logic                         avg_clear;
  logic                         rx_busy;
  logic                         sample_valid;
  logic [adc_pkg::sample_w-1:0] sample;

  // configuration and status
  adc_regs u_adc_regs (
    .clk33     (clk33),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .avg_valid (avg_valid),
    .avg_data  (avg_data),
    .enable    (enable),
    .avg_log2  (avg_log2),
    .period    (period),
    .avg_clear (avg_clear)
  );

  // start pulses, paced by the receiver
  adc_conv_timer u_adc_conv_timer (
    .clk33   (clk33),
    .rst     (rst),
    .enable  (enable),
    .period  (period),
    .rx_busy (rx_busy),
    .n_conv  (n_conv)
  );

  adc_serial_rx u_adc_serial_rx (
    .clk33        (clk33),
    .rst          (rst),
    .busy         (busy),
    .sclk         (sclk),
    .sdout        (sdout),
    .rx_busy      (rx_busy),
    .sample_valid (sample_valid),
    .sample       (sample)
  );

  adc_avg u_adc_avg (
    .clk33        (clk33),
    .rst          (rst),
    .avg_log2     (avg_log2),
    .avg_clear    (avg_clear),
    .sample_valid (sample_valid),
    .sample       (sample),
    .avg_valid    (avg_valid),
    .avg_data     (avg_data)
  );

endmodule

/* adc_dev_model.sv */
//----------------------------------------
// serial adc device model
//----------------------------------------

`timescale 1ns/1ps

module adc_dev_model (
  input  logic        clk33,
  input  logic        rst,
  // start request from the dut, active low
  input  logic        n_conv,
  // value the next conversion returns
  input  logic [15:0] next_sample,
  output logic        busy,
  output logic        sclk,
  output logic        sdout
);

  // sclk levels given so far, 32 per frame
  logic [5:0]  lvl;
  logic [15:0] shreg;

  always_ff @(posedge clk33) begin
    if (rst) begin
      busy  <= 1'b0;
      sclk  <= 1'b0;
      sdout <= 1'b0;
      lvl   <= '0;
      shreg <= '0;
    end else if (!busy) begin
      // start seen, msb goes out right away
      if (!n_conv) begin
        busy  <= 1'b1;
        sclk  <= 1'b0;
        sdout <= next_sample[15];
        shreg <= next_sample;
        lvl   <= '0;
      end
    end else if (lvl == 6'd32) begin
      // all 16 pairs sent, frame over
      busy <= 1'b0;
      sclk <= 1'b0;
    end else begin
      lvl  <= lvl + 1'b1;
      sclk <= ~sclk;
      // data moves on the falling edge only
      if (sclk) begin
        shreg <= {shreg[14:0], 1'b0};
        sdout <= shreg[14];
      end
    end
  end

endmodule

/* tb_adc_capture.sv */
//----------------------------------------
// adc capture path testbench
//----------------------------------------

`timescale 1ns/1ps

module tb_adc_capture;

  // 20 raw samples plus 5 groups of 4 and 3 groups of 8
  localparam int total_samples  = 20 + 5 * 4 + 3 * 8;
  localparam int max_period     = 60;
  localparam int timeout_cycles = total_samples * max_period + 2000;
  localparam int drain_cycles   = 200;

  logic        clk33;
  logic        rst;
  logic        wr_en;
  logic [1:0]  wr_addr;
  logic [15:0] wr_data;
  logic [1:0]  rd_addr;
  logic [15:0] rd_data;
  logic        n_conv;
  logic        busy;
  logic        sclk;
  logic        sdout;
  logic        avg_valid;
  logic [15:0] avg_data;
  logic [15:0] next_sample;

  // every value handed to the adc in start order
  logic [15:0] samples[$];
  int          rd_ptr;
  // results expected so far, tracks the count register
  int          n_results;
  int          cycles = 0;
  logic [31:0] rng;
  logic [15:0] val;

  adc_capture_top u_adc_capture_top (
    .clk33     (clk33),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .n_conv    (n_conv),
    .busy      (busy),
    .sclk      (sclk),
    .sdout     (sdout),
    .avg_valid (avg_valid),
    .avg_data  (avg_data)
  );

  adc_dev_model u_adc_dev_model (
    .clk33       (clk33),
    .rst         (rst),
    .n_conv      (n_conv),
    .next_sample (next_sample),
    .busy        (busy),
    .sclk        (sclk),
    .sdout       (sdout)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  //----------------------------------------
  // sample source
  //----------------------------------------
  always @(posedge clk33) begin
    if (rst) begin
      rng = xorshift32(32'd36662);
      next_sample <= rng[15:0];
    end else begin
      // model latches next_sample on this same edge
      if (!n_conv && !busy) begin
        samples.push_back(next_sample);
        rng = xorshift32(rng);
        next_sample <= rng[15:0];
      end
    end
  end

  // run limit
  always @(posedge clk33) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Verification failed");
      $fatal(1);
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] got);
    assert (got == exp) else begin
      $display("FAIL %s expected 0x%04h actual 0x%04h", name, exp, got);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
    @(posedge clk33);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    @(posedge clk33);
    wr_en   <= 1'b0;
  endtask

  // rd_data settles one edge after the address
  task automatic read_reg(input logic [1:0] addr, output logic [15:0] data);
    @(posedge clk33);
    rd_addr <= addr;
    @(posedge clk33);
    data = rd_data;
  endtask

  //----------------------------------------
  // one averaged result against the model
  //----------------------------------------
  task automatic collect_result(input string name, input logic [2:0] k);
    logic [31:0] sum;
    logic [31:0] mean;
    logic [15:0] got;
    logic [15:0] reg_val;
    int          group;
    int          i;
    group = 1 << k;
    @(posedge clk33);
    while (!avg_valid) begin
      @(posedge clk33);
    end
    got = avg_data;
    n_results++;
    assert (samples.size() - rd_ptr >= group) else
      stop_with_error("result came out before its samples were started");
    sum = '0;
    for (i = 0; i < group; i++) begin
      sum = sum + {16'd0, samples[rd_ptr]};
      rd_ptr++;
    end
    // floor of the group mean
    mean = sum >> k;
    check_value(name, mean[15:0], got);
    read_reg(adc_pkg::addr_result, reg_val);
    check_value("result register", mean[15:0], reg_val);
    read_reg(adc_pkg::addr_count, reg_val);
    check_value("count register", n_results[15:0], reg_val);
  endtask

  // clear enable and allow one in-flight result with no more starts after
  task automatic stop_and_drain(input logic [2:0] k);
    int extra;
    int i;
    extra = 0;
    write_reg(adc_pkg::addr_ctrl, {12'd0, k, 1'b0});
    for (i = 0; i < drain_cycles; i++) begin
      @(posedge clk33);
      if (avg_valid) begin
        extra++;
        n_results++;
      end
      // timer may still fire on the write edge itself
      if (i >= 1) begin
        assert (n_conv) else
          stop_with_error("n_conv went low after enable was cleared");
      end
    end
    assert (extra <= 1) else
      stop_with_error("more than one result arrived after enable was cleared");
  endtask

  task automatic run_capture(input string name, input logic [2:0] k,
                             input logic [15:0] period, input int n);
    int i;
    write_reg(adc_pkg::addr_period, period);
    // the new depth drops any partial group
    rd_ptr = samples.size();
    write_reg(adc_pkg::addr_ctrl, {12'd0, k, 1'b1});
    for (i = 0; i < n; i++) begin
      collect_result(name, k);
    end
    stop_and_drain(k);
  endtask

  initial begin
    clk33 = 1'b0;
    forever #10 clk33 = ~clk33;
  end

  initial begin
    rst       = 1'b1;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    rd_addr   = '0;
    rd_ptr    = 0;
    n_results = 0;
    repeat (2) @(posedge clk33);
    rst <= 1'b0;

    // register readback with enable kept low
    read_reg(adc_pkg::addr_period, val);
    check_value("period after reset", 16'd64, val);
    write_reg(adc_pkg::addr_ctrl, 16'h000a);
    read_reg(adc_pkg::addr_ctrl, val);
    check_value("ctrl readback", 16'h000a, val);
    write_reg(adc_pkg::addr_period, 16'd100);
    read_reg(adc_pkg::addr_period, val);
    check_value("period readback", 16'd100, val);
    write_reg(adc_pkg::addr_period, 16'd20);
    read_reg(adc_pkg::addr_period, val);
    check_value("period clamp", 16'd48, val);

    run_capture("raw capture", 3'd0, 16'd60, 20);
    run_capture("average of 4", 3'd2, 16'd48, 5);
    run_capture("average of 8", 3'd3, 16'd50, 3);

    $display("Verification passed");
    $finish;
  end

endmodule

/* all.f */
adc_pkg.sv
adc_regs.sv
adc_conv_timer.sv
adc_serial_rx.sv
adc_avg.sv
adc_capture_top.sv
adc_dev_model.sv
tb_adc_capture.sv

/* run.sh */
#!/bin/bash
# build with verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_adc_capture -f all.f > build.log 2>&1 || { echo "build error, see build.log"; exit 1; }
./obj_dir/Vtb_adc_capture > sim.log 2>&1
! grep -q "Verification failed" sim.log && grep -q "Verification passed" sim.log && echo "simulation ok" || { echo "simulation reported errors, see sim.log"; exit 1; }
